//--- verilog/rsa_pkg.sv
package rsa_pkg;

  // operand width for N, base, R mod N, R^2 mod N and results
  // R = 2**OPERAND_WIDTH
  localparam int OPERAND_WIDTH = 32;

  // exponent bits walked by the ladder, msb first
  localparam int EXP_BITS = 16;

  // ladder bit counter, holds EXP_BITS-1 down to 0
  localparam int EXP_CNT_WIDTH = 4;

  // multiplier iteration counter, counts up to OPERAND_WIDTH
  localparam int MONT_CNT_WIDTH = 6;

  // host opcodes, anything undefined behaves as nop
  typedef enum logic [1:0] {
    OP_NOP = 2'd0,
    OP_EXP = 2'd1
  } cmd_op_t;

  // operand index on the parameter port
  typedef enum logic [2:0] {
    PARAM_MODULUS  = 3'd0,
    PARAM_R_MOD_N  = 3'd1,
    PARAM_BASE     = 3'd2,
    PARAM_R2_MOD_N = 3'd3,
    PARAM_EXPONENT = 3'd4
  } param_sel_t;

  // exponentiation sequencer
  typedef enum logic [1:0] {
    ME_IDLE      = 2'd0,
    ME_TO_MONT   = 2'd1,
    ME_LADDER    = 2'd2,
    ME_FROM_MONT = 2'd3
  } modexp_state_t;

  // bit-serial multiplier
  typedef enum logic [1:0] {
    MM_IDLE = 2'd0,
    MM_ITER = 2'd1,
    MM_SUB  = 2'd2
  } mont_state_t;

endpackage

//--- verilog/montgomery_mult.sv
`timescale 1ns/1ps

module montgomery_mult import rsa_pkg::*; (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     start,
  input  logic [OPERAND_WIDTH-1:0] a,
  input  logic [OPERAND_WIDTH-1:0] b,
  input  logic [OPERAND_WIDTH-1:0] modulus,
  output logic                     done,
  output logic [OPERAND_WIDTH-1:0] product
);

  mont_state_t               state;
  logic [MONT_CNT_WIDTH-1:0] iter_cnt;
  // extra guard bit, acc stays below 2N
  logic [OPERAND_WIDTH:0]    acc;
  logic [OPERAND_WIDTH:0]    acc_red;
  logic [OPERAND_WIDTH-1:0]  a_sh;
  logic [OPERAND_WIDTH-1:0]  b_q;
  logic [OPERAND_WIDTH-1:0]  n_q;

  // one radix-2 step: add b if the a bit is set, make even with N, halve
  function automatic logic [OPERAND_WIDTH:0] mont_step(
    input logic [OPERAND_WIDTH:0]   acc_in,
    input logic                     a_bit,
    input logic [OPERAND_WIDTH-1:0] b_in,
    input logic [OPERAND_WIDTH-1:0] n_in
  );
    logic [OPERAND_WIDTH+1:0] sum;
    sum = {1'b0, acc_in} + (a_bit ? {2'b00, b_in} : '0);
    if (sum[0]) begin
      sum = sum + {2'b00, n_in};
    end
    return sum[OPERAND_WIDTH+1:1];
  endfunction

  // final reduction candidate
  assign acc_red = acc - {1'b0, n_q};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state    <= MM_IDLE;
      iter_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        MM_IDLE: begin
          // first iteration already runs on the start edge
          if (start) begin
            state    <= MM_ITER;
            iter_cnt <= MONT_CNT_WIDTH'(1);
          end
        end
        MM_ITER: begin
          iter_cnt <= iter_cnt + 1'b1;
          if (iter_cnt == MONT_CNT_WIDTH'(OPERAND_WIDTH - 1)) begin
            state <= MM_SUB;
          end
        end
        MM_SUB: begin
          state <= MM_IDLE;
          done  <= 1'b1;
        end
        default: state <= MM_IDLE;
      endcase
    end
  end

  // datapath, a consumed lsb first
  always_ff @(posedge clk) begin
    if (state == MM_IDLE && start) begin
      acc  <= mont_step('0, a[0], b, modulus);
      a_sh <= a >> 1;
      b_q  <= b;
      n_q  <= modulus;
    end else if (state == MM_ITER) begin
      acc  <= mont_step(acc, a_sh[0], b_q, n_q);
      a_sh <= a_sh >> 1;
    end else if (state == MM_SUB) begin
      // held until the next start
      product <= (acc >= {1'b0, n_q}) ? acc_red[OPERAND_WIDTH-1:0]
                                      : acc[OPERAND_WIDTH-1:0];
    end
  end

  // sequencer must wait for done before restarting
  a_no_restart: assert property (
    @(posedge clk) disable iff (!resetn)
    start |-> state == MM_IDLE
  ) else $error("multiplier started while busy");

endmodule

//--- verilog/rsa_cmd_decode.sv
`timescale 1ns/1ps

module rsa_cmd_decode import rsa_pkg::*; (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     param_valid,
  input  param_sel_t               param_sel,
  input  logic [OPERAND_WIDTH-1:0] param_data,
  output logic                     param_ready,
  input  logic                     cmd_valid,
  input  cmd_op_t                  cmd_op,
  output logic                     cmd_ready,
  input  logic                     result_free,
  output logic                     busy,
  output logic                     exp_start,
  output logic [OPERAND_WIDTH-1:0] modulus,
  output logic [OPERAND_WIDTH-1:0] r_mod_n,
  output logic [OPERAND_WIDTH-1:0] base,
  output logic [OPERAND_WIDTH-1:0] r2_mod_n,
  output logic [EXP_BITS-1:0]      exponent
);

  // set on an accepted exp and dropped once the result module holds data
  logic in_flight;
  logic param_fire;
  logic cmd_fire;
  logic exp_fire;

  // engine running or result still unread
  assign busy        = in_flight | ~result_free;
  assign param_ready = ~busy;
  assign cmd_ready   = ~busy;

  assign param_fire = param_valid & param_ready;
  assign cmd_fire   = cmd_valid & cmd_ready;

  // opcode decode
  // nop and undefined codes are simply consumed
  always_comb begin
    case (cmd_op)
      OP_EXP:  exp_fire = cmd_fire;
      default: exp_fire = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      in_flight <= 1'b0;
      exp_start <= 1'b0;
    end else begin
      // one cycle start pulse and the same edge raises busy
      exp_start <= exp_fire;
      if (!result_free) begin
        // result module now keeps busy high on its own
        in_flight <= 1'b0;
      end else if (exp_fire) begin
        in_flight <= 1'b1;
      end
    end
  end

  // operand registers
  // writes only land while idle so the engine sees stable values
  always_ff @(posedge clk) begin
    if (param_fire) begin
      case (param_sel)
        PARAM_MODULUS:  modulus  <= param_data;
        PARAM_R_MOD_N:  r_mod_n  <= param_data;
        PARAM_BASE:     base     <= param_data;
        PARAM_R2_MOD_N: r2_mod_n <= param_data;
        // only the low exponent bits are walked
        PARAM_EXPONENT: exponent <= param_data[EXP_BITS-1:0];
        default: begin
        end
      endcase
    end
  end

  // no start while the result module still holds an unread word
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!resetn)
    exp_start |-> result_free
  ) else $error("exp_start issued while a result is unread");

endmodule

//--- verilog/rsa_modexp.sv
`timescale 1ns/1ps

module rsa_modexp import rsa_pkg::*; (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     exp_start,
  input  logic [OPERAND_WIDTH-1:0] modulus,
  input  logic [OPERAND_WIDTH-1:0] r_mod_n,
  input  logic [OPERAND_WIDTH-1:0] base,
  input  logic [OPERAND_WIDTH-1:0] r2_mod_n,
  input  logic [EXP_BITS-1:0]      exponent,
  output logic                     exp_done,
  output logic [OPERAND_WIDTH-1:0] exp_result
);

  modexp_state_t            state;
  logic [EXP_CNT_WIDTH-1:0] bit_cnt;
  // ladder pair, acc = R0 and xm = R1 in Montgomery form
  logic [OPERAND_WIDTH-1:0] acc;
  logic [OPERAND_WIDTH-1:0] xm;
  logic                     mont_start_sq;
  logic                     mont_start_mul;
  logic                     sq_pend;
  logic                     mul_pend;
  logic                     sq_done;
  logic                     mul_done;
  logic [OPERAND_WIDTH-1:0] sq_product;
  logic [OPERAND_WIDTH-1:0] mul_product;
  logic [OPERAND_WIDTH-1:0] sq_a;
  logic [OPERAND_WIDTH-1:0] sq_b;
  logic [OPERAND_WIDTH-1:0] mul_a;
  logic [OPERAND_WIDTH-1:0] mul_b;
  logic                     cur_bit;
  logic                     last_bit;
  logic                     step_done;

  assign cur_bit  = exponent[bit_cnt];
  assign last_bit = (bit_cnt == '0);

  // every launched multiplier is finished, either earlier or right now
  assign step_done = (sq_pend | mul_pend) &
                     (!sq_pend | sq_done) &
                     (!mul_pend | mul_done);

  // squarer input: base*R^2 first, then whichever register the bit picks
  always_comb begin
    if (state == ME_TO_MONT) begin
      sq_a = base;
      sq_b = r2_mod_n;
    end else if (cur_bit) begin
      sq_a = xm;
      sq_b = xm;
    end else begin
      sq_a = acc;
      sq_b = acc;
    end
  end

  // multiply by one strips the R factor at the end
  assign mul_a = acc;
  assign mul_b = (state == ME_FROM_MONT) ? OPERAND_WIDTH'(1) : xm;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state          <= ME_IDLE;
      bit_cnt        <= '0;
      mont_start_sq  <= 1'b0;
      mont_start_mul <= 1'b0;
      sq_pend        <= 1'b0;
      mul_pend       <= 1'b0;
      exp_done       <= 1'b0;
    end else begin
      mont_start_sq  <= 1'b0;
      mont_start_mul <= 1'b0;
      exp_done       <= 1'b0;
      if (sq_done) begin
        sq_pend <= 1'b0;
      end
      if (mul_done) begin
        mul_pend <= 1'b0;
      end
      case (state)
        ME_IDLE: begin
          if (exp_start) begin
            state         <= ME_TO_MONT;
            bit_cnt       <= EXP_CNT_WIDTH'(EXP_BITS - 1);
            mont_start_sq <= 1'b1;
            sq_pend       <= 1'b1;
          end
        end
        ME_TO_MONT: begin
          if (step_done) begin
            state          <= ME_LADDER;
            mont_start_sq  <= 1'b1;
            mont_start_mul <= 1'b1;
            sq_pend        <= 1'b1;
            mul_pend       <= 1'b1;
          end
        end
        ME_LADDER: begin
          if (step_done) begin
            mont_start_mul <= 1'b1;
            mul_pend       <= 1'b1;
            if (last_bit) begin
              // only the multiply-by-one remains
              state <= ME_FROM_MONT;
            end else begin
              bit_cnt       <= bit_cnt - 1'b1;
              mont_start_sq <= 1'b1;
              sq_pend       <= 1'b1;
            end
          end
        end
        ME_FROM_MONT: begin
          if (step_done) begin
            state    <= ME_IDLE;
            exp_done <= 1'b1;
          end
        end
        default: state <= ME_IDLE;
      endcase
    end
  end

  // ladder registers
  // products stay valid after done, so both are read at step end
  always_ff @(posedge clk) begin
    if (state == ME_IDLE && exp_start) begin
      acc <= r_mod_n;
    end else if (step_done) begin
      case (state)
        ME_TO_MONT: xm <= sq_product;
        ME_LADDER: begin
          // bit 1: R0 = R0*R1, R1 = R1^2
          // bit 0: R1 = R0*R1, R0 = R0^2
          if (cur_bit) begin
            acc <= mul_product;
            xm  <= sq_product;
          end else begin
            acc <= sq_product;
            xm  <= mul_product;
          end
        end
        ME_FROM_MONT: acc <= mul_product;
        default: begin
        end
      endcase
    end
  end

  assign exp_result = acc;

  montgomery_mult mont_sq (
    .clk     (clk),
    .resetn  (resetn),
    .start   (mont_start_sq),
    .a       (sq_a),
    .b       (sq_b),
    .modulus (modulus),
    .done    (sq_done),
    .product (sq_product)
  );

  montgomery_mult mont_mul (
    .clk     (clk),
    .resetn  (resetn),
    .start   (mont_start_mul),
    .a       (mul_a),
    .b       (mul_b),
    .modulus (modulus),
    .done    (mul_done),
    .product (mul_product)
  );

  // result module captures on every high cycle
  a_done_pulse: assert property (
    @(posedge clk) disable iff (!resetn)
    exp_done |=> !exp_done
  ) else $error("exp_done held longer than one cycle");

endmodule

//--- verilog/rsa_result.sv
`timescale 1ns/1ps

module rsa_result import rsa_pkg::*; (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     exp_done,
  input  logic [OPERAND_WIDTH-1:0] exp_result,
  output logic                     result_valid,
  output logic [OPERAND_WIDTH-1:0] result_data,
  input  logic                     result_ready,
  output logic                     result_free
);

  // decode holds off new commands while a result waits
  assign result_free = ~result_valid;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      result_valid <= 1'b0;
    end else if (exp_done) begin
      result_valid <= 1'b1;
    end else if (result_valid && result_ready) begin
      // host took it
      result_valid <= 1'b0;
    end
  end

  // result word, written only on completion
  always_ff @(posedge clk) begin
    if (exp_done) begin
      result_data <= exp_result;
    end
  end

  // no new completion may land while the host stalls
  a_hold_data: assert property (
    @(posedge clk) disable iff (!resetn)
    result_valid && !result_ready |=> $stable(result_data)
  ) else $error("result_data changed under back-pressure");

endmodule

//--- verilog/rsa_top.sv
`timescale 1ns/1ps

module rsa_top import rsa_pkg::*; (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     param_valid,
  input  param_sel_t               param_sel,
  input  logic [OPERAND_WIDTH-1:0] param_data,
  output logic                     param_ready,
  input  logic                     cmd_valid,
  input  cmd_op_t                  cmd_op,
  output logic                     cmd_ready,
  output logic                     result_valid,
  output logic [OPERAND_WIDTH-1:0] result_data,
  input  logic                     result_ready,
  output logic                     busy
);

  // decode to engine
  logic                     exp_start;
  logic [OPERAND_WIDTH-1:0] modulus;
  logic [OPERAND_WIDTH-1:0] r_mod_n;
  logic [OPERAND_WIDTH-1:0] base;
  logic [OPERAND_WIDTH-1:0] r2_mod_n;
  logic [EXP_BITS-1:0]      exponent;
  // engine to result
  logic                     exp_done;
  logic [OPERAND_WIDTH-1:0] exp_result;
  // result back to decode
  logic                     result_free;

  rsa_cmd_decode rsa_cmd_decode_inst (
    .clk         (clk),
    .resetn      (resetn),
    .param_valid (param_valid),
    .param_sel   (param_sel),
    .param_data  (param_data),
    .param_ready (param_ready),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_ready   (cmd_ready),
    .result_free (result_free),
    .busy        (busy),
    .exp_start   (exp_start),
    .modulus     (modulus),
    .r_mod_n     (r_mod_n),
    .base        (base),
    .r2_mod_n    (r2_mod_n),
    .exponent    (exponent)
  );

  rsa_modexp rsa_modexp_inst (
    .clk        (clk),
    .resetn     (resetn),
    .exp_start  (exp_start),
    .modulus    (modulus),
    .r_mod_n    (r_mod_n),
    .base       (base),
    .r2_mod_n   (r2_mod_n),
    .exponent   (exponent),
    .exp_done   (exp_done),
    .exp_result (exp_result)
  );

  rsa_result rsa_result_inst (
    .clk          (clk),
    .resetn       (resetn),
    .exp_done     (exp_done),
    .exp_result   (exp_result),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_ready (result_ready),
    .result_free  (result_free)
  );

endmodule

//--- testbench/rsa_tb.sv
`timescale 1ns/1ps

module rsa_tb import rsa_pkg::*; ();

  // handshake and result waits, in cycles
  localparam int HS_LIMIT  = 100;
  localparam int RES_LIMIT = 5000;

  logic                     clk;
  logic                     resetn;
  logic                     param_valid;
  param_sel_t               param_sel;
  logic [OPERAND_WIDTH-1:0] param_data;
  logic                     param_ready;
  logic                     cmd_valid;
  cmd_op_t                  cmd_op;
  logic                     cmd_ready;
  logic                     result_valid;
  logic [OPERAND_WIDTH-1:0] result_data;
  logic                     result_ready;
  logic                     busy;
  int                       error_count;
  integer                   seed;

  rsa_top rsa_top_inst (
    .clk          (clk),
    .resetn       (resetn),
    .param_valid  (param_valid),
    .param_sel    (param_sel),
    .param_data   (param_data),
    .param_ready  (param_ready),
    .cmd_valid    (cmd_valid),
    .cmd_op       (cmd_op),
    .cmd_ready    (cmd_ready),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_ready (result_ready),
    .busy         (busy)
  );

  always #5 clk = ~clk;

  // reference model, plain 64-bit modular arithmetic
  function automatic logic [OPERAND_WIDTH-1:0] r_mod_n_of(input logic [31:0] n);
    logic [63:0] r;
    r = 64'h1_0000_0000 % {32'd0, n};
    return r[31:0];
  endfunction

  function automatic logic [OPERAND_WIDTH-1:0] r2_mod_n_of(input logic [31:0] n);
    logic [63:0] r;
    r = {32'd0, r_mod_n_of(n)};
    r = (r * r) % {32'd0, n};
    return r[31:0];
  endfunction

  // square and multiply, lsb first
  function automatic logic [OPERAND_WIDTH-1:0] mod_pow(input logic [31:0] x,
                                                       input logic [15:0] e,
                                                       input logic [31:0] n);
    logic [63:0] acc;
    logic [63:0] sq;
    logic [63:0] n64;
    n64 = {32'd0, n};
    acc = 64'd1 % n64;
    sq  = {32'd0, x} % n64;
    for (int i = 0; i < EXP_BITS; i++) begin
      if (e[i]) begin
        acc = (acc * sq) % n64;
      end
      sq = (sq * sq) % n64;
    end
    return acc[31:0];
  endfunction

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t ns: %s (got %h, expected %h)", $time, msg, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: %s did not happen", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "stopping on timeout");
  endtask

  // all tasks start and end on a rising edge
  task automatic write_operand(input param_sel_t sel, input logic [31:0] data);
    int cycles;
    cycles = 0;
    param_valid <= 1'b1;
    param_sel   <= sel;
    param_data  <= data;
    // ready read at the edge is the value the DUT used
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > HS_LIMIT) report_timeout("operand write accept");
    end while (!param_ready);
    param_valid <= 1'b0;
  endtask

  task automatic send_command(input cmd_op_t op);
    int cycles;
    cycles = 0;
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > HS_LIMIT) report_timeout("command accept");
    end while (!cmd_ready);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_for_result();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > RES_LIMIT) report_timeout("result_valid after OP_EXP");
    end while (!result_valid);
  endtask

  // one cycle of ready, valid is already high here
  task automatic take_result();
    result_ready <= 1'b1;
    @(posedge clk);
    result_ready <= 1'b0;
  endtask

  task automatic load_operands(input logic [31:0] n, input logic [31:0] x,
                               input logic [15:0] e);
    write_operand(PARAM_MODULUS, n);
    write_operand(PARAM_R_MOD_N, r_mod_n_of(n));
    write_operand(PARAM_BASE, x);
    write_operand(PARAM_R2_MOD_N, r2_mod_n_of(n));
    write_operand(PARAM_EXPONENT, {16'd0, e});
  endtask

  task automatic run_exp(input logic [31:0] n, input logic [31:0] x, input logic [15:0] e,
                         input logic [31:0] expected, input string tag);
    load_operands(n, x, e);
    send_command(OP_EXP);
    wait_for_result();
    check_equal(result_data, expected, tag);
    take_result();
  endtask

  task automatic check_reset_state();
    check_equal(param_ready, 1, "param_ready after reset");
    check_equal(cmd_ready, 1, "cmd_ready after reset");
    check_equal(busy, 0, "busy after reset");
    check_equal(result_valid, 0, "result_valid after reset");
  endtask

  task automatic fixed_vectors();
    run_exp(32'hF123_4567, 32'd2, 16'h0003, 32'd8, "2^3 mod N");
    run_exp(32'hF123_4567, 32'd2, 16'h0000, 32'd1, "2^0 mod N");
    run_exp(32'hF123_4567, 32'd2, 16'h0001, 32'd2, "2^1 mod N");
  endtask

  task automatic random_vectors();
    logic [31:0] n;
    logic [31:0] x;
    logic [31:0] e;
    for (int i = 0; i < 20; i++) begin
      // odd modulus, base below it
      n = $random(seed);
      n = n | 32'd1;
      x = $random(seed);
      x = x % n;
      e = $random(seed);
      run_exp(n, x, e[15:0], mod_pow(x, e[15:0], n), $sformatf("random set %0d", i));
    end
  endtask

  task automatic back_pressure();
    logic [31:0] expected;
    expected = mod_pow(32'h1234_5678, 16'hBEEF, 32'hC001_D00D);
    load_operands(32'hC001_D00D, 32'h1234_5678, 16'hBEEF);
    send_command(OP_EXP);
    // start pulse lands, then busy is up
    repeat (2) @(posedge clk);
    check_equal(busy, 1, "busy while running");
    wait_for_result();
    // host stalls
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      check_equal(result_valid, 1, "result_valid under back-pressure");
      check_equal(result_data, expected, "result_data under back-pressure");
      check_equal(cmd_ready, 0, "cmd_ready under back-pressure");
      check_equal(param_ready, 0, "param_ready under back-pressure");
      check_equal(busy, 1, "busy under back-pressure");
    end
    take_result();
    @(posedge clk);
    check_equal(busy, 0, "busy after result taken");
    check_equal(result_valid, 0, "result_valid after result taken");
    check_equal(cmd_ready, 1, "cmd_ready after result taken");
  endtask

  task automatic idle_for_cycles(input int cycles, input string tag);
    repeat (cycles) begin
      @(posedge clk);
      check_equal(busy, 0, {tag, " raised busy"});
      check_equal(result_valid, 0, {tag, " raised result_valid"});
    end
  endtask

  task automatic opcode_handling();
    send_command(OP_NOP);
    idle_for_cycles(50, "OP_NOP");
    // undefined codes fall back to nop
    send_command(cmd_op_t'(2'd2));
    idle_for_cycles(50, "opcode 2");
    send_command(cmd_op_t'(2'd3));
    idle_for_cycles(50, "opcode 3");
  endtask

  task automatic operand_retention();
    run_exp(32'h8000_0B41, 32'h0ABC_DEF1, 16'h00FF,
            mod_pow(32'h0ABC_DEF1, 16'h00FF, 32'h8000_0B41), "retention first run");
    // new exponent only, modulus and base kept from before
    write_operand(PARAM_EXPONENT, 32'h0000_A5A5);
    send_command(OP_EXP);
    wait_for_result();
    check_equal(result_data, mod_pow(32'h0ABC_DEF1, 16'hA5A5, 32'h8000_0B41),
                "retention second run");
    take_result();
  endtask

  initial begin
    clk          = 1'b0;
    resetn       = 1'b0;
    param_valid  = 1'b0;
    param_sel    = PARAM_MODULUS;
    param_data   = '0;
    cmd_valid    = 1'b0;
    cmd_op       = OP_NOP;
    result_ready = 1'b0;
    error_count  = 0;
    seed         = 32'h926;
    repeat (10) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    check_reset_state();
    fixed_vectors();
    random_vectors();
    back_pressure();
    opcode_handling();
    operand_retention();
    if (error_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- files.f
verilog/rsa_pkg.sv
verilog/montgomery_mult.sv
verilog/rsa_cmd_decode.sv
verilog/rsa_modexp.sv
verilog/rsa_result.sv
verilog/rsa_top.sv
testbench/rsa_tb.sv
